// ==== opl3_timer_host.f ====
opl3_timer_host_pkg.sv
synchronizer.sv
host_bus_decoder.sv
sw_detection_trick.sv
reg_write_cdc.sv
opl_timers.sv
opl3_timer_host_top.sv
tb_status_checker.sv
tb_opl3_timer_host.sv

// ==== Makefile ====
# Verilator flow for the opl3 timer and status path
# make lint | make sim | make clean ; variables can be set on the command line

VERILATOR ?= verilator
FILELIST  ?= opl3_timer_host.f
TB_TOP    ?= tb_opl3_timer_host
RTL_TOP   ?= opl3_timer_host_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass message on a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_opl3_timer_host.sv ====
// testbench for the opl3 timer and status path that runs the read-count
// detection trick, real overflows, masking and rst_irq through the host port
// while tb_status_checker compares every status read against expected_status
`timescale 1ns/1ps
`default_nettype none

module tb_opl3_timer_host;
    localparam real HOST_PERIOD_NS = 4.0;
    localparam real OPL_PERIOD_NS  = 10.0;
    localparam int  RESET_CYCLES   = 8;
    localparam int  CROSS_OPL      = 8;    // write crossing plus load in clk_opl cycles
    localparam int  STROBE_CYCLES  = 3;
    localparam int  IDLE_CYCLES    = 20;
    localparam int  SETTLE_CYCLES  = 40;   // before a read that expects a change
    localparam int  MAX_ACCESSES   = 130;  // all tests with the random read count at 19
    localparam int  WAIT_BUDGET    = 4 * SETTLE_CYCLES + 4 * 400;  // settle and overflow waits
    localparam int  TIMEOUT_CYCLES = RESET_CYCLES + MAX_ACCESSES * 24 + WAIT_BUDGET + 200;
    localparam int  N_READS        = opl3_timer_host_pkg::NUM_READS_TO_TRIGGER_OVERFLOW;
    localparam int  T1_TICK        = opl3_timer_host_pkg::TIMER1_TICK_CYCLES;
    localparam int  T2_TICK        = T1_TICK * opl3_timer_host_pkg::TIMER2_TICK_DIV;
    localparam opl3_timer_host_pkg::reg_addr_t CTRL_ADDR = opl3_timer_host_pkg::TIMER_CTRL_ADDR;
    localparam opl3_timer_host_pkg::reg_addr_t T1_ADDR   = opl3_timer_host_pkg::TIMER1_ADDR;
    localparam opl3_timer_host_pkg::reg_addr_t T2_ADDR   = opl3_timer_host_pkg::TIMER2_ADDR;

    logic                              clk_host;
    logic                              clk_opl;
    logic                              rst_n;
    logic                              cs_n;
    logic                              wr_n;
    logic                              rd_n;
    logic [1:0]                        address;
    opl3_timer_host_pkg::reg_data_t    din;
    opl3_timer_host_pkg::status_t      dout;
    opl3_timer_host_pkg::status_t      exp_status;     // handed to the checker per read
    int                                check_count;
    int                                dout_errors;
    int                                tb_errors    = 0;
    int                                reads_issued = 0;
    int                                cycle_count  = 0;
    integer                            seed         = 99601;

    // reference model state
    logic    m_start_t1  = 1'b0;
    logic    m_start_t2  = 1'b0;
    logic    m_mask_t1   = 1'b0;
    logic    m_mask_t2   = 1'b0;
    logic    m_flag_t1   = 1'b0;   // sticky flags folded in at each write
    logic    m_flag_t2   = 1'b0;
    logic    m_armed     = 1'b0;   // read trick armed by a timer 1 start
    int      m_reads     = 0;
    int      m_preset_t1 = 0;
    int      m_preset_t2 = 0;
    realtime m_ref_t1    = 0.0;    // time the timer began running unmasked
    realtime m_ref_t2    = 0.0;

    opl3_timer_host_top UUT (
        .clk_host, .clk_opl, .rst_n, .cs_n, .wr_n, .rd_n, .address, .din, .dout
    );

    tb_status_checker u_checker (
        .clk_host, .rst_n, .cs_n, .rd_n, .address, .dout,
        .expected    (exp_status),
        .check_count (check_count),
        .error_count (dout_errors)
    );

    initial begin
        clk_host = 1'b0;
        forever #(HOST_PERIOD_NS / 2.0) clk_host = ~clk_host;
    end

    initial begin
        clk_opl = 1'b0;
        forever #(OPL_PERIOD_NS / 2.0) clk_opl = ~clk_opl;
    end

    // latest time by which an overflow after `ticks` ticks shows up on dout
    function automatic realtime ovf_time_ns(input int ticks, input int tick_len);
        return ((ticks + 1) * tick_len + CROSS_OPL) * OPL_PERIOD_NS + 4 * HOST_PERIOD_NS;
    endfunction

    function automatic int ovf_wait_cycles(input int ticks, input int tick_len);
        return $rtoi(ovf_time_ns(ticks, tick_len) / HOST_PERIOD_NS) + 2;
    endfunction

    function automatic opl3_timer_host_pkg::status_t expected_status(input realtime now);
        opl3_timer_host_pkg::status_t s;
        logic                         t1;
        logic                         t2;
        t1 = m_flag_t1;
        t2 = m_flag_t2;
        if (m_start_t1 && !m_mask_t1
            && (now - m_ref_t1) >= ovf_time_ns(256 - m_preset_t1, T1_TICK))
            t1 = 1'b1;  // counted past 0xff
        if (m_start_t2 && !m_mask_t2
            && (now - m_ref_t2) >= ovf_time_ns(256 - m_preset_t2, T2_TICK))
            t2 = 1'b1;
        if (m_armed && m_reads >= N_READS && !m_mask_t1)
            t1 = 1'b1;  // forced by the read count
        s = '0;
        s[opl3_timer_host_pkg::STATUS_IRQ_BIT] = t1 || t2;
        s[opl3_timer_host_pkg::STATUS_T1_BIT]  = t1;
        s[opl3_timer_host_pkg::STATUS_T2_BIT]  = t2;
        return s;
    endfunction

    task automatic model_write(input opl3_timer_host_pkg::reg_addr_t addr,
                               input opl3_timer_host_pkg::reg_data_t value);
        opl3_timer_host_pkg::status_t now_status;
        logic                         run1_old;
        logic                         run2_old;
        now_status = expected_status($realtime);
        m_flag_t1  = now_status[opl3_timer_host_pkg::STATUS_T1_BIT];
        m_flag_t2  = now_status[opl3_timer_host_pkg::STATUS_T2_BIT];
        run1_old   = m_start_t1 && !m_mask_t1;
        run2_old   = m_start_t2 && !m_mask_t2;
        m_armed    = (addr == CTRL_ADDR) && value[opl3_timer_host_pkg::CTRL_START_T1_BIT];
        m_reads    = 0;  // any write restarts the read count
        if (addr == T1_ADDR) begin
            m_preset_t1 = int'(value);
        end else if (addr == T2_ADDR) begin
            m_preset_t2 = int'(value);
        end else if (addr == CTRL_ADDR && value[opl3_timer_host_pkg::CTRL_RST_IRQ_BIT]) begin
            m_flag_t1 = 1'b0;  // control bits unchanged
            m_flag_t2 = 1'b0;
        end else if (addr == CTRL_ADDR) begin
            m_start_t1 = value[opl3_timer_host_pkg::CTRL_START_T1_BIT];
            m_start_t2 = value[opl3_timer_host_pkg::CTRL_START_T2_BIT];
            m_mask_t1  = value[opl3_timer_host_pkg::CTRL_MASK_T1_BIT];
            m_mask_t2  = value[opl3_timer_host_pkg::CTRL_MASK_T2_BIT];
        end
        if (m_start_t1 && !m_mask_t1 && !run1_old)
            m_ref_t1 = $realtime;
        if (m_start_t2 && !m_mask_t2 && !run2_old)
            m_ref_t2 = $realtime;
    endtask

    task automatic wait_host(input int cycles);
        repeat (cycles) @(negedge clk_host);
    endtask

    // one host access with the strobe low for three cycles then twenty idle
    task automatic bus_access(input logic is_write, input logic a0,
                              input opl3_timer_host_pkg::reg_data_t value);
        @(negedge clk_host);
        cs_n    = 1'b0;
        address = {1'b0, a0};  // bank 0
        din     = value;
        if (is_write)
            wr_n = 1'b0;
        else
            rd_n = 1'b0;
        wait_host(STROBE_CYCLES);
        cs_n = 1'b1;
        wr_n = 1'b1;
        rd_n = 1'b1;
        wait_host(IDLE_CYCLES);
    endtask

    task automatic write_reg(input opl3_timer_host_pkg::reg_addr_t addr,
                             input opl3_timer_host_pkg::reg_data_t value);
        bus_access(1'b1, 1'b0, addr);  // address write
        model_write(addr, value);
        bus_access(1'b1, 1'b1, value);  // data write that gives reg_wr
    endtask

    task automatic read_status();
        exp_status = expected_status($realtime);
        bus_access(1'b0, 1'b0, 8'h00);
        reads_issued++;
        if (m_armed && m_reads < N_READS)
            m_reads++;
    endtask

    // stop timers and clear irq then start timer 1 and count reads
    task automatic detect_sequence(input int reads, input logic disarm);
        write_reg(CTRL_ADDR, 8'h60);
        write_reg(CTRL_ADDR, 8'h80);
        read_status();
        write_reg(T1_ADDR, 8'h00);
        write_reg(CTRL_ADDR, 8'h21);
        if (disarm)
            write_reg(T2_ADDR, 8'h00);  // any other write stops the count
        repeat (reads) read_status();
        wait_host(SETTLE_CYCLES);
        read_status();
    endtask

    task automatic overflow_run(input opl3_timer_host_pkg::reg_addr_t preset_addr,
                                input opl3_timer_host_pkg::reg_data_t preset,
                                input opl3_timer_host_pkg::reg_data_t ctrl,
                                input int                             cycles);
        write_reg(CTRL_ADDR, 8'h60);  // stop and mask both
        write_reg(CTRL_ADDR, 8'h80);  // clear flags
        write_reg(preset_addr, preset);
        write_reg(CTRL_ADDR, ctrl);   // one timer started and unmasked
        wait_host(cycles);
        read_status();
    endtask

    always @(posedge clk_host) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d clk_host cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int n;
        rst_n      = 1'b0;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        rd_n       = 1'b1;
        address    = 2'b00;
        din        = 8'h00;
        exp_status = 8'h00;
        wait_host(RESET_CYCLES);
        rst_n = 1'b1;
        wait_host(4);

        detect_sequence(N_READS, 1'b0);                          // forced overflow
        n = 1 + (($random(seed) & 32'h7fff_ffff) % (N_READS - 1));
        detect_sequence(n, 1'b0);                                // too few reads
        detect_sequence(N_READS, 1'b1);                          // disarmed by a write
        overflow_run(T1_ADDR, 8'hFE, 8'h01, ovf_wait_cycles(2, T1_TICK));
        overflow_run(T2_ADDR, 8'hFF, 8'h02, ovf_wait_cycles(1, T2_TICK));

        // masked timers then unmask, stop and clear with rst_irq
        write_reg(CTRL_ADDR, 8'h60);
        write_reg(CTRL_ADDR, 8'h80);
        write_reg(T1_ADDR, 8'hFE);
        write_reg(T2_ADDR, 8'hFF);
        write_reg(CTRL_ADDR, 8'h63);
        wait_host(ovf_wait_cycles(1, T2_TICK));
        read_status();
        write_reg(CTRL_ADDR, 8'h03);
        wait_host(ovf_wait_cycles(1, T2_TICK));
        read_status();
        write_reg(CTRL_ADDR, 8'h60);  // stopped with the flags kept
        read_status();
        write_reg(CTRL_ADDR, 8'h80);
        wait_host(SETTLE_CYCLES);
        read_status();

        wait_host(4);
        if (check_count != reads_issued) begin
            $display("checker compared %0d reads but %0d were issued", check_count, reads_issued);
            tb_errors++;
        end
        $display("run done: %0d reads checked, %0d errors", check_count, dout_errors + tb_errors);
        if (dout_errors + tb_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_status_checker.sv ====
// status checker for the opl3 timer testbench: watches host reads at the DUT
// ports and compares dout one clk_host cycle after each read edge
`timescale 1ns/1ps
`default_nettype none

module tb_status_checker (
    input  logic                         clk_host,
    input  logic                         rst_n,
    input  logic                         cs_n,
    input  logic                         rd_n,
    input  logic [1:0]                   address,
    input  opl3_timer_host_pkg::status_t dout,
    input  opl3_timer_host_pkg::status_t expected,
    output int                           check_count,
    output int                           error_count
);
    localparam opl3_timer_host_pkg::status_t MASK = opl3_timer_host_pkg::STATUS_FLAG_MASK;

    logic                         rd_act;    // read strobe low with chip select
    logic                         rd_prev;
    logic                         rd_edge;   // same edge the decoder sees
    logic                         pending;   // dout due for a compare this cycle
    opl3_timer_host_pkg::status_t exp_q;     // expected byte taken at the read edge

    assign rd_act  = !cs_n && !rd_n;
    assign rd_edge = rd_act && !rd_prev;

    always_ff @(posedge clk_host) begin
        if (!rst_n) begin
            rd_prev     <= 1'b0;
            pending     <= 1'b0;
            exp_q       <= '0;
            check_count <= 0;
            error_count <= 0;
        end else begin
            rd_prev <= rd_act;
            pending <= rd_edge;
            if (rd_edge)
                exp_q <= address[0] ? '0 : expected;  // only address 0 returns status
            if (pending) begin
                check_count <= check_count + 1;
                if ((dout & MASK) !== (exp_q & MASK)) begin
                    $display("[FAIL] time %0d ns: dout expected 0x%02h, got 0x%02h",
                             $time, exp_q & MASK, dout & MASK);
                    error_count <= error_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== opl3_timer_host_top.sv ====
// top of the opl3 timer and status path: host port in clk_host, timers in
// clk_opl, with writes, the forced overflow and the flags crossing between
`timescale 1ns/1ps
`default_nettype none

module opl3_timer_host_top (
    input  logic                           clk_host,
    input  logic                           clk_opl,
    input  logic                           rst_n,
    input  logic                           cs_n,
    input  logic                           wr_n,
    input  logic                           rd_n,
    input  logic [1:0]                     address,
    input  opl3_timer_host_pkg::reg_data_t din,
    output opl3_timer_host_pkg::status_t   dout
);
    logic                           reg_wr;
    logic                           reg_bank;
    opl3_timer_host_pkg::reg_addr_t reg_addr;
    opl3_timer_host_pkg::reg_data_t reg_data;
    logic                           rd_pulse;
    logic                           force_overflow;  // already in clk_opl
    logic                           opl_wr;
    opl3_timer_host_pkg::reg_addr_t opl_addr;
    opl3_timer_host_pkg::reg_data_t opl_data;
    logic [2:0]                     flags_opl;       // clk_opl domain
    logic [2:0]                     flags_host;      // synchronized copy

    host_bus_decoder u_decoder (
        .clk_host, .rst_n, .cs_n, .wr_n, .rd_n, .address, .din,
        .status_flags (flags_host),
        .reg_wr, .reg_bank, .reg_addr, .reg_data, .rd_pulse, .dout
    );

    sw_detection_trick u_trick (
        .clk_host, .clk_opl, .rst_n,
        .reg_wr, .reg_bank, .reg_addr, .reg_data, .rd_pulse,
        .force_overflow
    );

    reg_write_cdc u_wr_cdc (
        .clk_host, .clk_opl, .rst_n,
        .reg_wr, .reg_bank, .reg_addr, .reg_data,
        .opl_wr, .opl_addr, .opl_data
    );

    opl_timers u_timers (
        .clk_opl, .rst_n, .opl_wr, .opl_addr, .opl_data, .force_overflow,
        .status_flags (flags_opl)
    );

    // each flag is a slow level, synchronized bit by bit
    synchronizer sync_flag_t2 (
        .clk (clk_host), .rst_n (rst_n), .in (flags_opl[0]), .out (flags_host[0])
    );
    synchronizer sync_flag_t1 (
        .clk (clk_host), .rst_n (rst_n), .in (flags_opl[1]), .out (flags_host[1])
    );
    synchronizer sync_flag_irq (
        .clk (clk_host), .rst_n (rst_n), .in (flags_opl[2]), .out (flags_host[2])
    );

endmodule

`default_nettype wire

// ==== opl_timers.sv ====
// opl timer block in clk_opl: prescaler, timer 1 and timer 2 with presets,
// control register 0x04 and the overflow flags reported as status_flags
`timescale 1ns/1ps
`default_nettype none

module opl_timers (
    input  logic                           clk_opl,
    input  logic                           rst_n,
    input  logic                           opl_wr,
    input  opl3_timer_host_pkg::reg_addr_t opl_addr,
    input  opl3_timer_host_pkg::reg_data_t opl_data,
    input  logic                           force_overflow,
    output logic [2:0]                     status_flags
);
    localparam int PRE_W   = opl3_timer_host_pkg::PRESCALE_W;
    localparam int DIV_W   = opl3_timer_host_pkg::DIV_W;
    localparam int PRE_MAX = opl3_timer_host_pkg::TIMER1_TICK_CYCLES - 1;
    localparam int DIV_MAX = opl3_timer_host_pkg::TIMER2_TICK_DIV - 1;

    opl3_timer_host_pkg::reg_data_t t1_preset;
    opl3_timer_host_pkg::reg_data_t t2_preset;
    opl3_timer_host_pkg::reg_data_t t1_cnt;
    opl3_timer_host_pkg::reg_data_t t2_cnt;
    logic [PRE_W-1:0]               prescale;
    logic [DIV_W-1:0]               t2_div;      // counts timer 1 ticks for timer 2
    logic                           start_t1;
    logic                           start_t2;
    logic                           mask_t1;
    logic                           mask_t2;
    logic                           flag_t1;
    logic                           flag_t2;
    logic                           ctrl_wr;     // plain control write, no rst_irq
    logic                           rst_irq_wr;
    logic                           t1_load;     // start bit going 0 -> 1
    logic                           t2_load;
    logic                           t1_tick;
    logic                           t2_tick;
    logic                           t1_ovf;
    logic                           t2_ovf;

    assign rst_irq_wr = opl_wr && (opl_addr == opl3_timer_host_pkg::TIMER_CTRL_ADDR)
                        && opl_data[opl3_timer_host_pkg::CTRL_RST_IRQ_BIT];
    assign ctrl_wr    = opl_wr && (opl_addr == opl3_timer_host_pkg::TIMER_CTRL_ADDR)
                        && !opl_data[opl3_timer_host_pkg::CTRL_RST_IRQ_BIT];
    assign t1_load    = ctrl_wr && opl_data[opl3_timer_host_pkg::CTRL_START_T1_BIT] && !start_t1;
    assign t2_load    = ctrl_wr && opl_data[opl3_timer_host_pkg::CTRL_START_T2_BIT] && !start_t2;

    assign t1_tick = (prescale == PRE_W'(PRE_MAX));
    assign t2_tick = t1_tick && (t2_div == DIV_W'(DIV_MAX));
    assign t1_ovf  = start_t1 && t1_tick && (t1_cnt == 8'hFF);  // wrap past 0xff
    assign t2_ovf  = start_t2 && t2_tick && (t2_cnt == 8'hFF);

    // presets, written any time
    always_ff @(posedge clk_opl) begin
        if (opl_wr && opl_addr == opl3_timer_host_pkg::TIMER1_ADDR)
            t1_preset <= opl_data;
        if (opl_wr && opl_addr == opl3_timer_host_pkg::TIMER2_ADDR)
            t2_preset <= opl_data;
    end

    // control register; a rst_irq write leaves these bits alone
    always_ff @(posedge clk_opl) begin
        if (!rst_n) begin
            start_t1 <= 1'b0;
            start_t2 <= 1'b0;
            mask_t1  <= 1'b0;
            mask_t2  <= 1'b0;
        end else if (ctrl_wr) begin
            start_t1 <= opl_data[opl3_timer_host_pkg::CTRL_START_T1_BIT];
            start_t2 <= opl_data[opl3_timer_host_pkg::CTRL_START_T2_BIT];
            mask_t1  <= opl_data[opl3_timer_host_pkg::CTRL_MASK_T1_BIT];
            mask_t2  <= opl_data[opl3_timer_host_pkg::CTRL_MASK_T2_BIT];
        end
    end

    // free running prescaler and the timer 2 divider
    always_ff @(posedge clk_opl) begin
        if (!rst_n) begin
            prescale <= '0;
            t2_div   <= '0;
        end else begin
            prescale <= t1_tick ? '0 : prescale + PRE_W'(1);
            if (t1_tick)
                t2_div <= t2_div + DIV_W'(1);  // wraps after TIMER2_TICK_DIV ticks
        end
    end

    // up counters, reload from the preset on start and on overflow
    always_ff @(posedge clk_opl) begin
        if (!rst_n) begin
            t1_cnt <= '0;
            t2_cnt <= '0;
        end else begin
            if (t1_load || t1_ovf)
                t1_cnt <= t1_preset;
            else if (start_t1 && t1_tick)
                t1_cnt <= t1_cnt + 8'd1;
            if (t2_load || t2_ovf)
                t2_cnt <= t2_preset;
            else if (start_t2 && t2_tick)
                t2_cnt <= t2_cnt + 8'd1;
        end
    end

    // overflow flags, cleared only by rst_irq
    always_ff @(posedge clk_opl) begin
        if (!rst_n || rst_irq_wr) begin
            flag_t1 <= 1'b0;
            flag_t2 <= 1'b0;
        end else begin
            if ((t1_ovf || force_overflow) && !mask_t1)
                flag_t1 <= 1'b1;  // forced overflow from the read trick too
            if (t2_ovf && !mask_t2)
                flag_t2 <= 1'b1;
        end
    end

    assign status_flags[opl3_timer_host_pkg::FLAG_T1_IDX]  = flag_t1;
    assign status_flags[opl3_timer_host_pkg::FLAG_T2_IDX]  = flag_t2;
    assign status_flags[opl3_timer_host_pkg::FLAG_IRQ_IDX] = flag_t1 || flag_t2;

endmodule

`default_nettype wire

// ==== reg_write_cdc.sv ====
// carries bank 0 register writes from clk_host to clk_opl: address and data
// are held in clk_host while a toggle crosses and becomes one opl_wr pulse
`timescale 1ns/1ps
`default_nettype none

module reg_write_cdc (
    input  logic                           clk_host,
    input  logic                           clk_opl,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic                           reg_bank,
    input  opl3_timer_host_pkg::reg_addr_t reg_addr,
    input  opl3_timer_host_pkg::reg_data_t reg_data,
    output logic                           opl_wr,
    output opl3_timer_host_pkg::reg_addr_t opl_addr,
    output opl3_timer_host_pkg::reg_data_t opl_data
);
    logic                           bank0_wr;     // bank 1 never crosses
    logic                           wr_toggle;    // flips once per write, clk_host
    logic                           toggle_sync;  // toggle seen in clk_opl
    logic                           toggle_prev;  // edge detect flop
    opl3_timer_host_pkg::reg_addr_t addr_hold;
    opl3_timer_host_pkg::reg_data_t data_hold;

    assign bank0_wr = reg_wr && !reg_bank;

    always_ff @(posedge clk_host) begin
        if (!rst_n)
            wr_toggle <= 1'b0;
        else if (bank0_wr)
            wr_toggle <= !wr_toggle;
    end

    always_ff @(posedge clk_host) begin
        if (bank0_wr) begin
            addr_hold <= reg_addr;  // stable until the next write, paced by the host
            data_hold <= reg_data;
        end
    end

    synchronizer toggle_sync_i (
        .clk   (clk_opl),
        .rst_n (rst_n),
        .in    (wr_toggle),
        .out   (toggle_sync)
    );

    always_ff @(posedge clk_opl) begin
        if (!rst_n) begin
            toggle_prev <= 1'b0;
            opl_wr      <= 1'b0;
        end else begin
            toggle_prev <= toggle_sync;
            opl_wr      <= toggle_sync ^ toggle_prev;  // one pulse per toggle change
        end
    end

    assign opl_addr = addr_hold;  // read in clk_opl only with opl_wr
    assign opl_data = data_hold;

endmodule

`default_nettype wire

// ==== sw_detection_trick.sv ====
// counts host reads after the write that starts timer 1 and, after enough of
// them, forces a timer 1 overflow so read-timed detection loops still pass
`timescale 1ns/1ps
`default_nettype none

module sw_detection_trick (
    input  logic                           clk_host,
    input  logic                           clk_opl,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic                           reg_bank,
    input  opl3_timer_host_pkg::reg_addr_t reg_addr,
    input  opl3_timer_host_pkg::reg_data_t reg_data,
    input  logic                           rd_pulse,
    output logic                           force_overflow
);
    localparam int N_READS = opl3_timer_host_pkg::NUM_READS_TO_TRIGGER_OVERFLOW;
    localparam int CNT_W   = opl3_timer_host_pkg::READ_CNT_W;

    logic             start_wr;             // bank 0 write to 0x04 with start t1 set
    logic             armed;
    logic [CNT_W-1:0] rd_count;
    logic             host_force_overflow;  // held level for the synchronizer

    assign start_wr = reg_wr && !reg_bank
                      && (reg_addr == opl3_timer_host_pkg::TIMER_CTRL_ADDR)
                      && reg_data[opl3_timer_host_pkg::CTRL_START_T1_BIT];

    always_ff @(posedge clk_host) begin
        if (!rst_n) begin
            armed               <= 1'b0;
            rd_count            <= '0;
            host_force_overflow <= 1'b0;
        end else if (reg_wr) begin
            armed               <= start_wr;  // any other write disarms
            rd_count            <= '0;
            host_force_overflow <= 1'b0;
        end else if (armed && rd_pulse && !host_force_overflow) begin
            rd_count <= rd_count + CNT_W'(1);
            if (rd_count == CNT_W'(N_READS - 1))
                host_force_overflow <= 1'b1;  // count reaches the limit on this read
        end
    end

    synchronizer force_sync (
        .clk   (clk_opl),
        .rst_n (rst_n),
        .in    (host_force_overflow),
        .out   (force_overflow)
    );

endmodule

`default_nettype wire

// ==== host_bus_decoder.sv ====
// host port front end in clk_host that detects write and read strobes, turns
// address and data write pairs into one reg_wr pulse and returns the status byte
`timescale 1ns/1ps
`default_nettype none

module host_bus_decoder (
    input  logic                           clk_host,
    input  logic                           rst_n,
    input  logic                           cs_n,
    input  logic                           wr_n,
    input  logic                           rd_n,
    input  logic [1:0]                     address,
    input  opl3_timer_host_pkg::reg_data_t din,
    input  logic [2:0]                     status_flags,
    output logic                           reg_wr,
    output logic                           reg_bank,
    output opl3_timer_host_pkg::reg_addr_t reg_addr,
    output opl3_timer_host_pkg::reg_data_t reg_data,
    output logic                           rd_pulse,
    output opl3_timer_host_pkg::status_t   dout
);
    logic                               wr_act;      // write strobe active now
    logic                               wr_prev;     // write strobe last cycle
    logic                               rd_act;
    logic                               rd_prev;
    logic                               wr_edge;     // first cycle of a write
    logic                               rd_edge;     // first cycle of a read
    logic                               addr_wr;
    logic                               data_wr;
    opl3_timer_host_pkg::timer_state_t  phase;
    logic                               bank_q;      // bank of the last address write
    opl3_timer_host_pkg::reg_addr_t     addr_q;
    opl3_timer_host_pkg::status_t       status_next;

    assign wr_act  = !cs_n && !wr_n;
    assign rd_act  = !cs_n && !rd_n;
    assign wr_edge = wr_act && !wr_prev;
    assign rd_edge = rd_act && !rd_prev;
    assign addr_wr = wr_edge && !address[0];  // bit 0 low selects address write
    assign data_wr = wr_edge && address[0]
                     && (phase == opl3_timer_host_pkg::PHASE_ADDR_LATCHED);

    always_comb begin
        status_next = '0;
        status_next[opl3_timer_host_pkg::STATUS_T1_BIT] =
            status_flags[opl3_timer_host_pkg::FLAG_T1_IDX];
        status_next[opl3_timer_host_pkg::STATUS_T2_BIT] =
            status_flags[opl3_timer_host_pkg::FLAG_T2_IDX];
        status_next[opl3_timer_host_pkg::STATUS_IRQ_BIT] =
            status_flags[opl3_timer_host_pkg::FLAG_IRQ_IDX];  // set when either flag is set
    end

    always_ff @(posedge clk_host) begin
        if (!rst_n) begin
            wr_prev  <= 1'b0;
            rd_prev  <= 1'b0;
            phase    <= opl3_timer_host_pkg::PHASE_IDLE;
            reg_wr   <= 1'b0;
            rd_pulse <= 1'b0;
            dout     <= '0;
        end else begin
            wr_prev  <= wr_act;
            rd_prev  <= rd_act;
            reg_wr   <= data_wr;   // one cycle after the write edge
            rd_pulse <= rd_edge;
            if (addr_wr)
                phase <= opl3_timer_host_pkg::PHASE_ADDR_LATCHED;
            if (rd_edge)
                dout <= address[0] ? '0 : status_next;  // only address 0 holds status
        end
    end

    // address latch and the values handed out with reg_wr
    always_ff @(posedge clk_host) begin
        if (addr_wr) begin
            bank_q <= address[1];
            addr_q <= din;
        end
        if (data_wr) begin
            reg_bank <= bank_q;  // held until the next data write
            reg_addr <= addr_q;
            reg_data <= din;
        end
    end

endmodule

`default_nettype wire

// ==== synchronizer.sv ====
// two-flop level synchronizer into the clock given on clk
// used for the write toggle, the force-overflow level and the status flags
`timescale 1ns/1ps
`default_nettype none

module synchronizer (
    input  logic clk,
    input  logic rst_n,
    input  logic in,
    output logic out
);
    logic meta;  // first stage, may go metastable

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta <= 1'b0;
            out  <= 1'b0;
        end else begin
            meta <= in;
            out  <= meta;  // settled copy
        end
    end

endmodule

`default_nettype wire

// ==== opl3_timer_host_pkg.sv ====
// shared widths, register map, control bit positions and timing constants
// for the opl3 timer and status path; rtl and testbench use scoped names
`default_nettype none

package opl3_timer_host_pkg;

    typedef logic [7:0] reg_data_t;  // one register data byte
    typedef logic [7:0] reg_addr_t;  // register address within a bank
    typedef logic [7:0] status_t;    // status byte returned to the host

    typedef enum logic {
        PHASE_IDLE,          // no register address written yet
        PHASE_ADDR_LATCHED   // address held, data writes go through
    } timer_state_t;

    localparam reg_addr_t TIMER1_ADDR     = 8'h02;  // timer 1 preset
    localparam reg_addr_t TIMER2_ADDR     = 8'h03;  // timer 2 preset
    localparam reg_addr_t TIMER_CTRL_ADDR = 8'h04;  // start, mask, rst_irq

    localparam int CTRL_RST_IRQ_BIT  = 7;
    localparam int CTRL_MASK_T1_BIT  = 6;
    localparam int CTRL_MASK_T2_BIT  = 5;
    localparam int CTRL_START_T2_BIT = 1;
    localparam int CTRL_START_T1_BIT = 0;

    localparam int STATUS_IRQ_BIT = 7;  // positions in the status byte
    localparam int STATUS_T1_BIT  = 6;
    localparam int STATUS_T2_BIT  = 5;

    localparam int FLAG_IRQ_IDX = 2;    // positions in the 3-bit flag bus
    localparam int FLAG_T1_IDX  = 1;
    localparam int FLAG_T2_IDX  = 0;

    localparam int TIMER1_TICK_CYCLES            = 16;  // clk_opl cycles per timer 1 tick
    localparam int TIMER2_TICK_DIV               = 4;   // timer 1 ticks per timer 2 tick
    localparam int NUM_READS_TO_TRIGGER_OVERFLOW = 20;
    localparam status_t STATUS_FLAG_MASK         = 8'hE0;

    localparam int PRESCALE_W = $clog2(TIMER1_TICK_CYCLES);
    localparam int DIV_W      = $clog2(TIMER2_TICK_DIV);
    localparam int READ_CNT_W = $clog2(NUM_READS_TO_TRIGGER_OVERFLOW + 1);

endpackage

`default_nettype wire
